// File: Makefile
TOP = cpl_gen_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '** PASS **' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: src/cpl_beat_counter.sv
`timescale 1ns/1ps

module cpl_beat_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_accept_i,  // New packet starts
  input  logic               with_data_i,   // Captured cmd is CplD
  input  logic               data_xfer_i,   // Data beat accepted
  input  cpl_pkg::byte_cnt_t byte_count_i,  // Captured byte count
  output cpl_pkg::beat_cnt_t extra_beats_o, // Beats after the header
  output cpl_pkg::beat_cnt_t beat_idx_o,    // Current data beat
  output logic               no_extra_o,    // Header carries all data
  output logic               last_data_o    // Current data beat is final
);

  cpl_pkg::byte_cnt_t bytes_clamped;
  cpl_pkg::byte_cnt_t beats_full;   // Ceiling result before narrowing
  cpl_pkg::beat_cnt_t beat_idx_q;

  // Payload buffer holds MAX_BYTES at most
  assign bytes_clamped = (byte_count_i > cpl_pkg::byte_cnt_t'(cpl_pkg::MAX_BYTES)) ?
                         cpl_pkg::byte_cnt_t'(cpl_pkg::MAX_BYTES) : byte_count_i;

  // First DW rides in the header beat, rest goes 16 bytes per beat
  assign beats_full = (with_data_i && bytes_clamped > 12'd4) ?
                      ((bytes_clamped - 12'd4 + 12'd15) >> 4) : 12'd0;

  assign extra_beats_o = beats_full[1:0];  // At most 2 with 32 bytes
  assign no_extra_o    = (extra_beats_o == 2'd0);

  // --------------------------------------------------
  // Data beat index
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_idx_q <= 2'd0;
    end else if (cmd_accept_i) begin
      beat_idx_q <= 2'd0;               // Fresh packet
    end else if (data_xfer_i) begin
      beat_idx_q <= beat_idx_q + 2'd1;  // Next data beat
    end
  end

  assign beat_idx_o  = beat_idx_q;
  assign last_data_o = (beat_idx_q == extra_beats_o - 2'd1);

endmodule

// File: src/cpl_beat_mux.sv
`timescale 1ns/1ps

module cpl_beat_mux (
  input  logic               in_hdr_i,      // Header beat phase
  input  logic               in_data_i,     // Data beat phase
  input  logic               last_data_i,   // Final data beat
  input  cpl_pkg::hdr_t      hdr_i,
  input  cpl_pkg::payload_t  payload_i,
  input  logic               with_data_i,
  input  cpl_pkg::be_t       first_be_i,
  input  cpl_pkg::be_t       last_be_i,
  input  cpl_pkg::beat_cnt_t extra_beats_i,
  input  cpl_pkg::beat_cnt_t beat_idx_i,
  output cpl_pkg::beat_t     cpl_data_o,
  output logic               cpl_sop_o,
  output logic               cpl_eop_o,
  output cpl_pkg::be_t       cpl_be_o
);

  localparam int DW = cpl_pkg::DW_W;

  logic hdr_only;  // Packet ends on the header beat

  assign hdr_only = (extra_beats_i == 2'd0);

  always_comb begin
    cpl_data_o = '0;  // Idle bus is all zero
    cpl_sop_o  = 1'b0;
    cpl_eop_o  = 1'b0;
    cpl_be_o   = 4'h0;

    // --------------------------------------------------
    // Header beat, payload DW0 in the top DW
    // --------------------------------------------------
    if (in_hdr_i) begin
      cpl_data_o[cpl_pkg::HDR_W-1:0] = hdr_i;
      if (with_data_i) begin
        cpl_data_o[cpl_pkg::BEAT_W-1:cpl_pkg::HDR_W] = payload_i[DW-1:0];
      end
      cpl_sop_o = 1'b1;
      cpl_eop_o = hdr_only;
      cpl_be_o  = (with_data_i && hdr_only) ? first_be_i : 4'hF;
    end

    // --------------------------------------------------
    // Data beats
    // --------------------------------------------------
    else if (in_data_i) begin
      case (beat_idx_i)
        2'd0: begin
          cpl_data_o = payload_i[5*DW-1:DW];         // DW1 to DW4
        end
        2'd1: begin
          cpl_data_o[3*DW-1:0] = payload_i[8*DW-1:5*DW];  // DW5 to DW7
        end
        default: begin
          cpl_data_o = '0;  // Beyond 32 bytes
        end
      endcase
      cpl_eop_o = last_data_i;
      cpl_be_o  = last_data_i ? last_be_i : 4'hF;
    end
  end

endmodule

// File: src/cpl_ctrl_fsm.sv
`timescale 1ns/1ps

module cpl_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_valid_i,      // Command offered
  input  logic cpl_ready_i,      // Stream sink ready
  input  logic credit_hdr_ok_i,  // Header credit available
  input  logic credit_data_ok_i, // Data credit available
  input  logic with_data_i,      // Captured cmd is CplD
  input  logic no_extra_i,       // Header beat is the last beat
  input  logic last_data_i,      // Current data beat is final
  output logic cmd_ready_o,
  output logic cmd_accept_o,     // Command transfer this cycle
  output logic cpl_valid_o,
  output logic in_hdr_o,         // Header beat on the stream
  output logic in_data_o,        // Data beat on the stream
  output logic data_xfer_o       // Data beat accepted
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_CRED,
    SEND_HDR,
    SEND_DATA
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   cred_ok;  // Credits needed by this packet

  // Data credit only matters for CplD
  assign cred_ok = credit_hdr_ok_i && (credit_data_ok_i || !with_data_i);

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;  // Hold by default
    case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          state_d = WAIT_CRED;  // Command taken
        end
      end
      WAIT_CRED: begin
        if (cred_ok) begin
          state_d = SEND_HDR;   // Valid rises next cycle
        end
      end
      SEND_HDR: begin
        if (cpl_ready_i) begin
          state_d = no_extra_i ? IDLE : SEND_DATA;  // Header accepted
        end
      end
      SEND_DATA: begin
        if (cpl_ready_i && last_data_i) begin
          state_d = IDLE;       // Eop beat accepted
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // Outputs, all from the registered state
  // --------------------------------------------------
  assign cmd_ready_o  = (state_q == IDLE);
  assign cmd_accept_o = cmd_valid_i && cmd_ready_o;
  assign in_hdr_o     = (state_q == SEND_HDR);
  assign in_data_o    = (state_q == SEND_DATA);
  assign cpl_valid_o  = in_hdr_o || in_data_o;   // Stable until accepted
  assign data_xfer_o  = in_data_o && cpl_ready_i;

endmodule

// File: src/cpl_gen_top.sv
`timescale 1ns/1ps

module cpl_gen_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpl_pkg::req_id_t     completer_id_i,
  input  cpl_pkg::cpl_status_t cmd_status_i,
  input  cpl_pkg::byte_cnt_t   cmd_byte_count_i,
  input  cpl_pkg::req_id_t     cmd_requester_id_i,
  input  cpl_pkg::tag_t        cmd_tag_i,
  input  cpl_pkg::low_addr_t   cmd_lower_addr_i,
  input  logic                 cmd_has_data_i,
  input  cpl_pkg::be_t         cmd_first_be_i,
  input  cpl_pkg::be_t         cmd_last_be_i,
  input  cpl_pkg::payload_t    cmd_payload_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  logic                 credit_hdr_ok_i,
  input  logic                 credit_data_ok_i,
  output cpl_pkg::beat_t       cpl_data_o,
  output logic                 cpl_sop_o,
  output logic                 cpl_eop_o,
  output cpl_pkg::be_t         cpl_be_o,
  output logic                 cpl_valid_o,
  input  logic                 cpl_ready_i
);

  logic               cmd_accept;   // FSM to header builder
  logic               in_hdr;
  logic               in_data;
  logic               data_xfer;
  logic               with_data;
  logic               no_extra;
  logic               last_data;
  cpl_pkg::byte_cnt_t byte_count;
  cpl_pkg::beat_cnt_t extra_beats;
  cpl_pkg::beat_cnt_t beat_idx;
  cpl_pkg::hdr_t      hdr;
  cpl_pkg::payload_t  payload;
  cpl_pkg::be_t       first_be;
  cpl_pkg::be_t       last_be;

  cpl_ctrl_fsm u_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_valid_i      (cmd_valid_i),
    .cpl_ready_i      (cpl_ready_i),
    .credit_hdr_ok_i  (credit_hdr_ok_i),
    .credit_data_ok_i (credit_data_ok_i),
    .with_data_i      (with_data),
    .no_extra_i       (no_extra),
    .last_data_i      (last_data),
    .cmd_ready_o      (cmd_ready_o),
    .cmd_accept_o     (cmd_accept),
    .cpl_valid_o      (cpl_valid_o),
    .in_hdr_o         (in_hdr),
    .in_data_o        (in_data),
    .data_xfer_o      (data_xfer)
  );

  cpl_beat_counter u_cnt (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_accept_i  (cmd_accept),
    .with_data_i   (with_data),
    .data_xfer_i   (data_xfer),
    .byte_count_i  (byte_count),
    .extra_beats_o (extra_beats),
    .beat_idx_o    (beat_idx),
    .no_extra_o    (no_extra),
    .last_data_o   (last_data)
  );

  cpl_hdr_builder u_hdr (
    .clk                (clk),
    .rst_n              (rst_n),
    .cmd_accept_i       (cmd_accept),
    .completer_id_i     (completer_id_i),
    .cmd_requester_id_i (cmd_requester_id_i),
    .cmd_status_i       (cmd_status_i),
    .cmd_byte_count_i   (cmd_byte_count_i),
    .cmd_tag_i          (cmd_tag_i),
    .cmd_lower_addr_i   (cmd_lower_addr_i),
    .cmd_has_data_i     (cmd_has_data_i),
    .cmd_first_be_i     (cmd_first_be_i),
    .cmd_last_be_i      (cmd_last_be_i),
    .cmd_payload_i      (cmd_payload_i),
    .hdr_o              (hdr),
    .with_data_o        (with_data),
    .byte_count_o       (byte_count),
    .payload_o          (payload),
    .first_be_o         (first_be),
    .last_be_o          (last_be)
  );

  cpl_beat_mux u_mux (
    .in_hdr_i      (in_hdr),
    .in_data_i     (in_data),
    .last_data_i   (last_data),
    .hdr_i         (hdr),
    .payload_i     (payload),
    .with_data_i   (with_data),
    .first_be_i    (first_be),
    .last_be_i     (last_be),
    .extra_beats_i (extra_beats),
    .beat_idx_i    (beat_idx),
    .cpl_data_o    (cpl_data_o),
    .cpl_sop_o     (cpl_sop_o),
    .cpl_eop_o     (cpl_eop_o),
    .cpl_be_o      (cpl_be_o)
  );

endmodule

// File: src/cpl_hdr_builder.sv
`timescale 1ns/1ps

module cpl_hdr_builder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_accept_i,       // Capture strobe
  input  cpl_pkg::req_id_t     completer_id_i,     // Own ID, static
  input  cpl_pkg::req_id_t     cmd_requester_id_i,
  input  cpl_pkg::cpl_status_t cmd_status_i,
  input  cpl_pkg::byte_cnt_t   cmd_byte_count_i,
  input  cpl_pkg::tag_t        cmd_tag_i,
  input  cpl_pkg::low_addr_t   cmd_lower_addr_i,
  input  logic                 cmd_has_data_i,
  input  cpl_pkg::be_t         cmd_first_be_i,
  input  cpl_pkg::be_t         cmd_last_be_i,
  input  cpl_pkg::payload_t    cmd_payload_i,
  output cpl_pkg::hdr_t        hdr_o,
  output logic                 with_data_o,        // CplD packet
  output cpl_pkg::byte_cnt_t   byte_count_o,
  output cpl_pkg::payload_t    payload_o,
  output cpl_pkg::be_t         first_be_o,
  output cpl_pkg::be_t         last_be_o
);

  cpl_pkg::cpl_status_t status_q;
  logic                 has_data_q;
  cpl_pkg::req_id_t     requester_id_q;
  cpl_pkg::byte_cnt_t   byte_count_q;
  cpl_pkg::tag_t        tag_q;
  cpl_pkg::low_addr_t   lower_addr_q;
  cpl_pkg::be_t         first_be_q;
  cpl_pkg::be_t         last_be_q;
  cpl_pkg::payload_t    payload_q;
  cpl_pkg::dw_cnt_t     length;

  // --------------------------------------------------
  // Command capture
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q   <= cpl_pkg::CPL_SC;
      has_data_q <= 1'b0;
    end else if (cmd_accept_i) begin
      status_q   <= cmd_status_i;
      has_data_q <= cmd_has_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_accept_i) begin
      requester_id_q <= cmd_requester_id_i;
      byte_count_q   <= cmd_byte_count_i;
      tag_q          <= cmd_tag_i;
      lower_addr_q   <= cmd_lower_addr_i;
      first_be_q     <= cmd_first_be_i;
      last_be_q      <= cmd_last_be_i;
      payload_q      <= cmd_payload_i;
    end
  end

  // UR and CRS never carry data
  assign with_data_o = has_data_q && (status_q == cpl_pkg::CPL_SC);

  // Length in DW, rounded up
  assign length = cpl_pkg::dw_cnt_t'((byte_count_q + 12'd3) >> 2);

  // --------------------------------------------------
  // Header layout, byte 0 first
  // --------------------------------------------------
  always_comb begin
    hdr_o        = '0;
    hdr_o[7:0]   = with_data_o ? cpl_pkg::FMT_CPLD : cpl_pkg::FMT_CPL;
    hdr_o[15:8]  = 8'h00;                   // TC 0, no attributes
    hdr_o[23:16] = {6'b0, length[9:8]};     // Length high bits
    hdr_o[31:24] = length[7:0];
    hdr_o[39:32] = completer_id_i[15:8];
    hdr_o[47:40] = completer_id_i[7:0];
    hdr_o[55:53] = status_q;
    hdr_o[52]    = 1'b0;                    // BCM
    hdr_o[51:48] = byte_count_q[11:8];
    hdr_o[63:56] = byte_count_q[7:0];
    hdr_o[71:64] = requester_id_q[15:8];
    hdr_o[79:72] = requester_id_q[7:0];
    hdr_o[87:80] = tag_q;
    hdr_o[94:88] = lower_addr_q;
    hdr_o[95]    = 1'b0;                    // Reserved
  end

  assign byte_count_o = byte_count_q;
  assign payload_o    = payload_q;
  assign first_be_o   = first_be_q;
  assign last_be_o    = last_be_q;

endmodule

// File: src/cpl_pkg.sv
package cpl_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int DW_W      = 32;          // One double word
  localparam int BEAT_W    = 128;         // Stream beat, 4 DW
  localparam int HDR_W     = 96;          // 3 DW completion header
  localparam int PAYLOAD_W = 256;         // 8 DW payload buffer
  localparam int MAX_BYTES = 32;          // Largest supported byte count

  // --------------------------------------------------
  // Field types
  // --------------------------------------------------
  typedef logic [BEAT_W-1:0]    beat_t;
  typedef logic [HDR_W-1:0]     hdr_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;
  typedef logic [11:0]          byte_cnt_t;   // Byte count field
  typedef logic [9:0]           dw_cnt_t;     // Length field in DW
  typedef logic [15:0]          req_id_t;     // Bus/dev/func
  typedef logic [7:0]           tag_t;
  typedef logic [6:0]           low_addr_t;
  typedef logic [3:0]           be_t;
  typedef logic [2:0]           cpl_status_t;
  typedef logic [1:0]           beat_cnt_t;   // Data beats after header

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  localparam logic [7:0] FMT_CPL  = 8'h0A;  // 3DW, no data
  localparam logic [7:0] FMT_CPLD = 8'h4A;  // 3DW, with data

  localparam cpl_status_t CPL_SC  = 3'd0;   // Successful completion
  localparam cpl_status_t CPL_UR  = 3'd1;   // Unsupported request
  localparam cpl_status_t CPL_CRS = 3'd2;   // Config retry status

endpackage

// File: verification/cpl_clk_gen.sv
`timescale 1ns/1ps

module cpl_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;               // Reset held from time 0
    repeat (5) @(negedge clk_o);  // Five full periods
    rst_n_o = 1'b1;               // Released away from the rising edge
  end

  // --------------------------------------------------
  // Free running clock
  // --------------------------------------------------
  always #50 clk_o = ~clk_o;      // 100 ns period

endmodule

// File: verification/cpl_gen_tb.sv
`timescale 1ns/1ps

module cpl_gen_tb;

  localparam int NUM_CMDS        = 83;                   // All phases together
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + 200;  // Per command budget plus margin

  logic                 clk;
  logic                 rst_n;
  cpl_pkg::req_id_t     completer_id;
  cpl_pkg::cpl_status_t cmd_status;
  cpl_pkg::byte_cnt_t   cmd_byte_count;
  cpl_pkg::req_id_t     cmd_requester_id;
  cpl_pkg::tag_t        cmd_tag;
  cpl_pkg::low_addr_t   cmd_lower_addr;
  logic                 cmd_has_data;
  cpl_pkg::be_t         cmd_first_be;
  cpl_pkg::be_t         cmd_last_be;
  cpl_pkg::payload_t    cmd_payload;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 credit_hdr_ok;
  logic                 credit_data_ok;
  cpl_pkg::beat_t       cpl_data;
  logic                 cpl_sop;
  logic                 cpl_eop;
  cpl_pkg::be_t         cpl_be;
  logic                 cpl_valid;
  logic                 cpl_ready;

  logic [133:0]   beat_q [$];   // {be, eop, sop, data} per expected beat
  logic           exp_present;  // Model holds a beat
  cpl_pkg::beat_t exp_data;
  logic           exp_sop;
  logic           exp_eop;
  cpl_pkg::be_t   exp_be;
  logic           busy;         // Command taken but eop not yet accepted
  logic           need_data;    // Packet in flight is CplD
  logic           took_beat;    // Beat accepted at the last rising edge
  logic           rand_ready;   // Sink back-pressure on
  logic           cred_needed;
  int             pkts_done;
  int             cmds_sent;

  cpl_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cpl_gen_top dut0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .completer_id_i     (completer_id),
    .cmd_status_i       (cmd_status),
    .cmd_byte_count_i   (cmd_byte_count),
    .cmd_requester_id_i (cmd_requester_id),
    .cmd_tag_i          (cmd_tag),
    .cmd_lower_addr_i   (cmd_lower_addr),
    .cmd_has_data_i     (cmd_has_data),
    .cmd_first_be_i     (cmd_first_be),
    .cmd_last_be_i      (cmd_last_be),
    .cmd_payload_i      (cmd_payload),
    .cmd_valid_i        (cmd_valid),
    .cmd_ready_o        (cmd_ready),
    .credit_hdr_ok_i    (credit_hdr_ok),
    .credit_data_ok_i   (credit_data_ok),
    .cpl_data_o         (cpl_data),
    .cpl_sop_o          (cpl_sop),
    .cpl_eop_o          (cpl_eop),
    .cpl_be_o           (cpl_be),
    .cpl_valid_o        (cpl_valid),
    .cpl_ready_i        (cpl_ready)
  );

  // --------------------------------------------------
  // Error exits
  // --------------------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string msg);
    abort_run($sformatf("Fail at %0d ns: %s", $time, msg));
  endtask

  // --------------------------------------------------
  // Expected-beat model
  // --------------------------------------------------
  function automatic cpl_pkg::hdr_t build_header(input logic cpld,
      input cpl_pkg::cpl_status_t status, input cpl_pkg::byte_cnt_t bc,
      input cpl_pkg::req_id_t rid, input cpl_pkg::tag_t tag,
      input cpl_pkg::low_addr_t laddr);
    logic [7:0]    b [0:11];
    logic [9:0]    len_dw;
    cpl_pkg::hdr_t hdr;
    int            i;
    len_dw = 10'((int'(bc) + 3) / 4);              // Whole DWs rounded up
    b[0]   = cpld ? cpl_pkg::FMT_CPLD : cpl_pkg::FMT_CPL;
    b[1]   = 8'h00;
    b[2]   = {6'b0, len_dw[9:8]};
    b[3]   = len_dw[7:0];
    b[4]   = completer_id[15:8];
    b[5]   = completer_id[7:0];
    b[6]   = {status, 1'b0, bc[11:8]};             // Status, BCM, count high
    b[7]   = bc[7:0];
    b[8]   = rid[15:8];
    b[9]   = rid[7:0];
    b[10]  = tag;
    b[11]  = {1'b0, laddr};
    for (i = 0; i < 12; i++) begin
      hdr[8*i +: 8] = b[i];                        // Byte 0 in the low bits
    end
    return hdr;
  endfunction

  task automatic refresh_expect();
    if (beat_q.size() > 0) begin
      {exp_be, exp_eop, exp_sop, exp_data} = beat_q[0];
      exp_present = 1'b1;
    end else begin
      {exp_be, exp_eop, exp_sop, exp_data} = '0;
      exp_present = 1'b0;
    end
  endtask

  task automatic push_beat(input cpl_pkg::beat_t data, input logic sop, input logic eop,
      input cpl_pkg::be_t be);
    beat_q.push_back({be, eop, sop, data});
  endtask

  task automatic expect_packet(input cpl_pkg::cpl_status_t status,
      input cpl_pkg::byte_cnt_t bc, input logic has_data, input cpl_pkg::req_id_t rid,
      input cpl_pkg::tag_t tag, input cpl_pkg::low_addr_t laddr, input cpl_pkg::be_t fbe,
      input cpl_pkg::be_t lbe, input cpl_pkg::payload_t payload);
    logic           cpld;
    int             tail_dw;
    int             extra;
    int             idx;
    int             i;
    int             k;
    cpl_pkg::beat_t beat;
    cpld    = has_data && (status == cpl_pkg::CPL_SC);     // UR and CRS drop data
    tail_dw = cpld ? ((int'(bc) + 3) / 4) - 1 : 0;         // DWs after header DW0
    extra   = (tail_dw + 3) / 4;
    beat    = '0;
    beat[95:0] = build_header(cpld, status, bc, rid, tag, laddr);
    if (cpld) begin
      beat[127:96] = payload[31:0];
    end
    push_beat(beat, 1'b1, extra == 0, (cpld && extra == 0) ? fbe : 4'hF);
    for (i = 0; i < extra; i++) begin
      beat = '0;
      for (k = 0; k < 4; k++) begin
        idx = 1 + 4 * i + k;
        if (idx < 8) begin
          beat[32*k +: 32] = payload[32*idx +: 32];        // Past DW7 stays zero
        end
      end
      push_beat(beat, 1'b0, i == extra - 1, (i == extra - 1) ? lbe : 4'hF);
    end
    refresh_expect();
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic cpl_pkg::byte_cnt_t rand_data_bytes();
    return 12'(1 + ($urandom % 32));    // 1 to 32
  endfunction

  function automatic cpl_pkg::byte_cnt_t rand_any_bytes();
    return 12'(1 + ($urandom % 4095));  // Full field range
  endfunction

  task automatic send_cmd(input cpl_pkg::cpl_status_t status, input cpl_pkg::byte_cnt_t bc,
      input logic has_data);
    cpl_pkg::payload_t payload;
    int                k;
    for (k = 0; k < 8; k++) begin
      payload[32*k +: 32] = $urandom;
    end
    cmd_status       = status;
    cmd_byte_count   = bc;
    cmd_has_data     = has_data;
    cmd_requester_id = 16'($urandom);
    cmd_tag          = 8'($urandom);
    cmd_lower_addr   = 7'($urandom);
    cmd_first_be     = 4'($urandom);
    cmd_last_be      = 4'($urandom);
    cmd_payload      = payload;
    expect_packet(status, bc, has_data, cmd_requester_id, cmd_tag, cmd_lower_addr,
                  cmd_first_be, cmd_last_be, payload);
    cmds_sent++;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      @(negedge clk);                   // Previous packet still in flight
    end
    @(negedge clk);                     // Taken on the rising edge in between
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (!cmd_ready) begin
      @(negedge clk);
    end
  endtask

  task automatic drive_ready();
    forever begin
      @(negedge clk);
      cpl_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;  // 3 in 4 when random
    end
  endtask

  // --------------------------------------------------
  // Handshake tracking
  // --------------------------------------------------
  assign cred_needed = credit_hdr_ok && (credit_data_ok || !need_data);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      need_data <= 1'b0;
      took_beat <= 1'b0;
      pkts_done <= 0;
    end else begin
      took_beat <= cpl_valid && cpl_ready;
      if (cmd_valid && cmd_ready) begin
        busy      <= 1'b1;
        need_data <= cmd_has_data && (cmd_status == cpl_pkg::CPL_SC);
      end else if (cpl_valid && cpl_ready && cpl_eop) begin
        busy      <= 1'b0;
        pkts_done <= pkts_done + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (took_beat && beat_q.size() > 0) begin
      void'(beat_q.pop_front());        // Front beat went out
    end
    refresh_expect();
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_beat_match: assert property (@(posedge clk) disable iff (!rst_n)
    (cpl_valid && cpl_ready) |-> (exp_present && cpl_data == exp_data && cpl_sop == exp_sop
                                  && cpl_eop == exp_eop && cpl_be == exp_be))
    else flag_mismatch($sformatf("beat differs, expected data %h sop %b eop %b be %h",
                                 exp_data, exp_sop, exp_eop, exp_be));

  a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (cpl_valid && !cpl_ready) |=> (cpl_valid && $stable(cpl_data) && $stable(cpl_sop)
                                   && $stable(cpl_eop) && $stable(cpl_be)))
    else flag_mismatch("beat dropped or changed under back-pressure");

  a_cmd_ready: assert property (@(posedge clk) disable iff (!rst_n) cmd_ready == !busy)
    else flag_mismatch("cmd_ready does not match the packet in flight");

  a_cred_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && !cpl_valid && !cred_needed) |=> !cpl_valid)
    else flag_mismatch("valid rose without the needed credits");

  a_cred_go: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && !cpl_valid && cred_needed) |=> cpl_valid)
    else flag_mismatch("valid missing one cycle after credits were seen");

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    cpl_pkg::cpl_status_t status;
    logic                 has;
    int                   n;
    int                   sel;
    void'($urandom(56));
    completer_id     = 16'($urandom);
    cmd_status       = cpl_pkg::CPL_SC;
    cmd_byte_count   = '0;
    cmd_requester_id = '0;
    cmd_tag          = '0;
    cmd_lower_addr   = '0;
    cmd_has_data     = 1'b0;
    cmd_first_be     = '0;
    cmd_last_be      = '0;
    cmd_payload      = '0;
    cmd_valid        = 1'b0;
    credit_hdr_ok    = 1'b1;
    credit_data_ok   = 1'b1;
    cpl_ready        = 1'b1;
    rand_ready       = 1'b0;
    cmds_sent        = 0;
    refresh_expect();
    fork
      drive_ready();
    join_none
    @(posedge rst_n);
    @(negedge clk);
    assert (!cpl_valid && cmd_ready) else flag_mismatch("state after reset is not idle");

    // Header-only completions where UR and CRS ignore the data flag
    send_cmd(cpl_pkg::CPL_SC, rand_any_bytes(), 1'b0);
    wait_idle();
    send_cmd(cpl_pkg::CPL_UR, rand_any_bytes(), 1'b1);
    wait_idle();
    send_cmd(cpl_pkg::CPL_CRS, rand_any_bytes(), 1'b1);
    wait_idle();

    // CplD at the beat boundaries then random counts
    send_cmd(cpl_pkg::CPL_SC, 12'd1, 1'b1);
    send_cmd(cpl_pkg::CPL_SC, 12'd4, 1'b1);
    send_cmd(cpl_pkg::CPL_SC, 12'd5, 1'b1);
    send_cmd(cpl_pkg::CPL_SC, 12'd20, 1'b1);
    send_cmd(cpl_pkg::CPL_SC, 12'd21, 1'b1);
    send_cmd(cpl_pkg::CPL_SC, 12'd32, 1'b1);
    for (n = 0; n < 30; n++) begin
      send_cmd(cpl_pkg::CPL_SC, rand_data_bytes(), 1'b1);
    end
    wait_idle();

    // Credit gating
    credit_data_ok = 1'b0;
    send_cmd(cpl_pkg::CPL_SC, 12'd24, 1'b1);
    repeat (6) @(negedge clk);          // Held in credit wait
    credit_data_ok = 1'b1;
    wait_idle();
    credit_hdr_ok = 1'b0;
    send_cmd(cpl_pkg::CPL_SC, 12'd8, 1'b1);
    repeat (5) @(negedge clk);
    credit_hdr_ok = 1'b1;
    wait_idle();
    credit_data_ok = 1'b0;              // Header credit alone is enough here
    send_cmd(cpl_pkg::CPL_SC, rand_any_bytes(), 1'b0);
    wait_idle();
    send_cmd(cpl_pkg::CPL_UR, rand_any_bytes(), 1'b1);
    wait_idle();
    credit_data_ok = 1'b1;

    // Random back-pressure with mixed commands
    rand_ready = 1'b1;
    for (n = 0; n < 40; n++) begin
      sel    = $urandom % 4;
      has    = 1'($urandom);
      status = (sel == 2) ? cpl_pkg::CPL_UR : (sel == 3) ? cpl_pkg::CPL_CRS : cpl_pkg::CPL_SC;
      if (status == cpl_pkg::CPL_SC && has) begin
        send_cmd(status, rand_data_bytes(), 1'b1);
      end else begin
        send_cmd(status, rand_any_bytes(), has);
      end
    end
    wait_idle();
    rand_ready = 1'b0;
    repeat (3) @(negedge clk);

    if (beat_q.size() != 0 || pkts_done != cmds_sent) begin
      flag_mismatch($sformatf("%0d of %0d packets done, %0d beats never sent",
                              pkts_done, cmds_sent, beat_q.size()));
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  initial begin
    #(WATCHDOG_CYCLES * 100);
    abort_run($sformatf("Timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

// File: vlog.f
src/cpl_pkg.sv
src/cpl_ctrl_fsm.sv
src/cpl_beat_counter.sv
src/cpl_hdr_builder.sv
src/cpl_beat_mux.sv
src/cpl_gen_top.sv
verification/cpl_clk_gen.sv
verification/cpl_gen_tb.sv
